/* src.f */
div_cfg_pkg.sv
div_ctrl_pkg.sv
pu_div_operands.sv
pu_div_step_counter.sv
pu_div_fsm.sv
pu_div_core.sv
pu_div_out.sv
pu_div.sv
tb_clk_gen.sv
tb_pu_div.sv

/* Bender.yml */
package:
  name: pu_div

sources:
  - div_cfg_pkg.sv
  - div_ctrl_pkg.sv
  - pu_div_operands.sv
  - pu_div_step_counter.sv
  - pu_div_fsm.sv
  - pu_div_core.sv
  - pu_div_out.sv
  - pu_div.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_pu_div.sv

/* tb_pu_div.sv */
module tb_pu_div;
    import div_cfg_pkg::*;

    localparam int    SEED           = 89160;
    localparam int    RESULT_LATENCY = STEP_COUNT + 3;
    localparam int    RANDOM_RUNS    = 40;
    localparam int    TIMEOUT_CYCLES = 60 * 25 + 100;  // 60 runs of 25 cycles plus margin.
    localparam attr_t INVALID_MASK   = attr_t'(1) << INVALID;

    logic  clk;
    logic  rst;
    logic  signal_sel;
    logic  signal_wr;
    logic  signal_oe;
    data_t data_in;
    attr_t attr_in;
    data_t data_out;
    attr_t attr_out;

    // expected bus values during a read.
    logic  check_en;
    data_t exp_data;
    attr_t exp_attr;

    int cycle_count = 0;

    tb_clk_gen i_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    pu_div i_dut (
        .clk        (clk),
        .rst        (rst),
        .signal_sel (signal_sel),
        .signal_wr  (signal_wr),
        .signal_oe  (signal_oe),
        .data_in    (data_in),
        .attr_in    (attr_in),
        .data_out   (data_out),
        .attr_out   (attr_out)
    );

    // a zero divisor gives an all-ones quotient.
    function automatic data_t model_quotient(input data_t num, input data_t den);
        if (den == '0) begin
            return '1;
        end
        return num / den;
    endfunction

    function automatic data_t model_remainder(input data_t num, input data_t den);
        if (den == '0) begin
            return num;
        end
        return num % den;
    endfunction

    function automatic logic model_invalid(input attr_t num_attr, input attr_t den_attr,
                                           input data_t den);
        return num_attr[INVALID] || den_attr[INVALID] || (den == '0);
    endfunction

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("ERR %s expected 0x%0h got 0x%0h", name, expected, actual);
        $display("TB FAILED");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic write_operand(input logic sel, input data_t value, input attr_t attr);
        @(posedge clk);
        signal_sel <= sel;
        signal_wr  <= 1'b1;
        signal_oe  <= 1'b0;
        data_in    <= value;
        attr_in    <= attr;
    endtask

    // start strobe for one cycle, then the bus goes idle.
    task automatic strobe_start(input logic sel, input data_t value, input attr_t attr);
        @(posedge clk);
        signal_sel <= sel;
        signal_wr  <= 1'b1;
        signal_oe  <= 1'b1;
        data_in    <= value;
        attr_in    <= attr;
        @(posedge clk);
        signal_wr  <= 1'b0;
        signal_oe  <= 1'b0;
    endtask

    task automatic wait_result();
        repeat (RESULT_LATENCY) @(posedge clk);
    endtask

    task automatic read_result(input data_t quot, input data_t rem, input logic inv);
        @(posedge clk);
        signal_sel <= 1'b0;
        signal_wr  <= 1'b0;
        signal_oe  <= 1'b1;
        check_en   <= 1'b1;
        exp_data   <= quot;
        exp_attr   <= inv ? INVALID_MASK : attr_t'(0);
        @(posedge clk);
        signal_sel <= 1'b1;  // remainder read.
        exp_data   <= rem;
        @(posedge clk);
        signal_oe  <= 1'b0;
        check_en   <= 1'b0;
    endtask

    task automatic run_division(input data_t num, input attr_t num_attr,
                                input data_t den, input attr_t den_attr);
        write_operand(1'b0, den, den_attr);
        write_operand(1'b1, num, num_attr);
        strobe_start(1'b0, '0, '0);
        wait_result();
        read_result(model_quotient(num, den), model_remainder(num, den),
                    model_invalid(num_attr, den_attr, den));
    endtask

    // writes with signal_oe high double as starts and must not touch the staging.
    task automatic check_blocked_write();
        run_division(16'd50000, '0, 16'd7, '0);
        strobe_start(1'b0, 16'd3, INVALID_MASK);
        wait_result();
        read_result(16'd7142, 16'd6, 1'b0);
        strobe_start(1'b1, 16'd9, INVALID_MASK);
        wait_result();
        read_result(16'd7142, 16'd6, 1'b0);
        strobe_start(1'b0, '0, '0);  // latches whatever the numerator strobe left.
        wait_result();
        read_result(16'd7142, 16'd6, 1'b0);
    endtask

    task automatic check_ignored_restart();
        write_operand(1'b0, 16'd13, '0);
        write_operand(1'b1, 16'd40000, '0);
        strobe_start(1'b0, '0, '0);
        write_operand(1'b0, 16'd100, '0);
        write_operand(1'b1, 16'd999, '0);
        strobe_start(1'b0, '0, '0);  // reaches the FSM while it runs.
        repeat (RESULT_LATENCY - 4) @(posedge clk);
        read_result(16'd3076, 16'd12, 1'b0);
        // the staged second operands are still there for the next start.
        strobe_start(1'b0, '0, '0);
        wait_result();
        read_result(16'd9, 16'd99, 1'b0);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    a_read_data: assert property (@(posedge clk) disable iff (rst)
        check_en |-> data_out == exp_data)
        else report_value("data_out", $sampled(exp_data), $sampled(data_out));

    a_read_attr: assert property (@(posedge clk) disable iff (rst)
        check_en |-> attr_out == exp_attr)
        else report_value("attr_out", $sampled(exp_attr), $sampled(attr_out));

    a_idle_data: assert property (@(posedge clk) disable iff (rst)
        !(signal_oe && !signal_wr) |-> data_out == '0)
        else report_value("data_out", 0, $sampled(data_out));

    a_idle_attr: assert property (@(posedge clk) disable iff (rst)
        !(signal_oe && !signal_wr) |-> attr_out == '0)
        else report_value("attr_out", 0, $sampled(attr_out));

    a_attr_spare: assert property (@(posedge clk) disable iff (rst)
        (attr_out & ~INVALID_MASK) == '0)
        else report_value("attr_out", $sampled(attr_out) & INVALID_MASK, $sampled(attr_out));

    initial begin
        data_t num;
        data_t den;
        attr_t num_attr;
        attr_t den_attr;

        void'($urandom(SEED));
        signal_sel <= 1'b0;
        signal_wr  <= 1'b0;
        signal_oe  <= 1'b0;
        data_in    <= '0;
        attr_in    <= '0;
        check_en   <= 1'b0;
        exp_data   <= '0;
        exp_attr   <= '0;

        @(negedge rst);
        @(posedge clk);

        read_result('0, '0, 1'b0);  // nothing computed yet.

        for (int i = 0; i < RANDOM_RUNS; i++) begin
            num      = data_t'($urandom);
            den      = data_t'($urandom) >> ($urandom % DATA_WIDTH);
            num_attr = attr_t'($urandom) & ~INVALID_MASK;
            den_attr = attr_t'($urandom) & ~INVALID_MASK;
            if (den == '0) begin
                den = 16'd1;
            end
            run_division(num, num_attr, den, den_attr);
        end

        // zero denominator.
        run_division(16'h0000, '0, 16'h0000, '0);
        run_division(16'hffff, '0, 16'h0000, '0);
        run_division(data_t'($urandom), '0, 16'h0000, '0);

        // attribute flags, spare bits never reach the output.
        run_division(16'd1000, INVALID_MASK, 16'd33, '0);
        run_division(16'd1000, '0, 16'd33, INVALID_MASK);
        run_division(16'd1000, INVALID_MASK, 16'd33, INVALID_MASK);
        run_division(16'd1000, ~INVALID_MASK, 16'd33, ~INVALID_MASK);

        check_blocked_write();
        check_ignored_restart();

        repeat (2) @(posedge clk);  // let the last checks run.
        $display("TB PASSED");
        $finish;
    end

endmodule

/* tb_clk_gen.sv */
module tb_clk_gen (
    output logic clk,
    output logic rst
);
    localparam int HALF_PERIOD  = 50;  // period of 100 time units.
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* pu_div.sv */
module pu_div (
    input  logic               clk,
    input  logic               rst,
    input  logic               signal_sel,
    input  logic               signal_wr,
    input  logic               signal_oe,
    input  div_cfg_pkg::data_t data_in,
    input  div_cfg_pkg::attr_t attr_in,
    output div_cfg_pkg::data_t data_out,
    output div_cfg_pkg::attr_t attr_out
);
    import div_ctrl_pkg::*;

    operand_t numer;
    operand_t denom;
    result_t  result;
    logic     start;
    logic     load;
    logic     clear;
    logic     step_en;
    logic     last;
    logic     done;

    pu_div_operands i_operands (
        .clk        (clk),
        .rst        (rst),
        .signal_sel (signal_sel),
        .signal_wr  (signal_wr),
        .signal_oe  (signal_oe),
        .data_in    (data_in),
        .attr_in    (attr_in),
        .numer      (numer),
        .denom      (denom),
        .start      (start)
    );

    pu_div_fsm i_fsm (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .last    (last),
        .load    (load),
        .clear   (clear),
        .step_en (step_en),
        .done    (done)
    );

    pu_div_step_counter i_step_counter (
        .clk     (clk),
        .rst     (rst),
        .clear   (clear),
        .step_en (step_en),
        .last    (last)
    );

    pu_div_core i_core (
        .clk     (clk),
        .rst     (rst),
        .load    (load),
        .step_en (step_en),
        .numer   (numer),
        .denom   (denom),
        .result  (result)
    );

    pu_div_out i_out (
        .clk        (clk),
        .rst        (rst),
        .done       (done),
        .result     (result),
        .signal_sel (signal_sel),
        .signal_wr  (signal_wr),
        .signal_oe  (signal_oe),
        .data_out   (data_out),
        .attr_out   (attr_out)
    );

endmodule

/* pu_div_out.sv */
module pu_div_out (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  done,
    input  div_ctrl_pkg::result_t result,
    input  logic                  signal_sel,
    input  logic                  signal_wr,
    input  logic                  signal_oe,
    output div_cfg_pkg::data_t    data_out,
    output div_cfg_pkg::attr_t    attr_out
);
    import div_cfg_pkg::*;
    import div_ctrl_pkg::*;

    result_t result_q;
    logic    rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            result_q <= '0;
        end else if (done) begin
            result_q <= result;
        end
    end

    assign rd = signal_oe && !signal_wr;

    always_comb begin
        data_out = '0;
        attr_out = '0;
        if (rd) begin
            data_out          = signal_sel ? result_q.remain : result_q.quotient;
            attr_out[INVALID] = result_q.invalid;  // other attribute bits stay zero.
        end
    end

endmodule

/* pu_div_core.sv */
module pu_div_core (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load,
    input  logic                   step_en,
    input  div_ctrl_pkg::operand_t numer,
    input  div_ctrl_pkg::operand_t denom,
    output div_ctrl_pkg::result_t  result
);
    import div_cfg_pkg::*;

    data_t divisor;
    data_t quot_shift;  // dividend bits leave at the top, quotient bits enter at the bottom.
    data_t partial;     // partial remainder.
    logic  invalid;

    logic [DATA_WIDTH:0]   shifted;
    logic [DATA_WIDTH+1:0] trial;
    logic                  fits;

    // one restoring step.
    always_comb begin
        shifted = {partial, quot_shift[DATA_WIDTH-1]};
        trial   = {1'b0, shifted} - {2'b00, divisor};
        fits    = !trial[DATA_WIDTH+1];  // difference not negative.
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            divisor    <= '0;
            quot_shift <= '0;
            partial    <= '0;
            invalid    <= 1'b0;
        end else if (load) begin
            divisor    <= denom.value;
            quot_shift <= numer.value;
            partial    <= '0;
            invalid    <= numer.invalid || denom.invalid || (denom.value == '0);
        end else if (step_en) begin
            if (fits) begin
                partial    <= trial[DATA_WIDTH-1:0];
                quot_shift <= {quot_shift[DATA_WIDTH-2:0], 1'b1};
            end else begin
                partial    <= shifted[DATA_WIDTH-1:0];
                quot_shift <= {quot_shift[DATA_WIDTH-2:0], 1'b0};
            end
        end
    end

    // a zero divisor always fits: all-ones quotient, remainder is the numerator.
    assign result.quotient = quot_shift;
    assign result.remain   = partial;
    assign result.invalid  = invalid;

endmodule

/* pu_div_fsm.sv */
module pu_div_fsm (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic last,
    output logic load,
    output logic clear,
    output logic step_en,
    output logic done
);
    import div_ctrl_pkg::*;

    div_state_t state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            load    <= 1'b0;
            clear   <= 1'b0;
            step_en <= 1'b0;
            done    <= 1'b0;
        end else begin
            // single-cycle pulses by default.
            load  <= 1'b0;
            clear <= 1'b0;
            done  <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_RUN;
                        load  <= 1'b1;
                        clear <= 1'b1;
                    end
                end

                ST_RUN: begin
                    // start is not looked at here, so a busy unit drops it.
                    if (step_en && last) begin
                        state   <= ST_DONE;
                        step_en <= 1'b0;
                        done    <= 1'b1;
                    end else begin
                        step_en <= 1'b1;  // first run cycle is the core load.
                    end
                end

                ST_DONE: begin
                    state <= ST_IDLE;
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* pu_div_step_counter.sv */
module pu_div_step_counter (
    input  logic clk,
    input  logic rst,
    input  logic clear,
    input  logic step_en,
    output logic last
);
    import div_cfg_pkg::*;

    step_t idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            idx <= '0;
        end else if (clear) begin
            idx <= '0;  // clear wins over a step.
        end else if (step_en) begin
            idx <= idx + 1'b1;  // wraps after the last step.
        end
    end

    // high during the final step of a division.
    assign last = (idx == step_t'(STEP_COUNT - 1));

endmodule

/* pu_div_operands.sv */
module pu_div_operands (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   signal_sel,
    input  logic                   signal_wr,
    input  logic                   signal_oe,
    input  div_cfg_pkg::data_t     data_in,
    input  div_cfg_pkg::attr_t     attr_in,
    output div_ctrl_pkg::operand_t numer,
    output div_ctrl_pkg::operand_t denom,
    output logic                   start
);
    import div_cfg_pkg::*;

    data_t numer_stage;
    data_t denom_stage;
    attr_t numer_attr;
    attr_t denom_attr;
    logic  bus_start;

    assign bus_start = signal_oe && signal_wr;

    // staging registers, written only while the bus is not reading or starting.
    always_ff @(posedge clk) begin
        if (rst) begin
            numer_stage <= '0;
            denom_stage <= '0;
            numer_attr  <= '0;
            denom_attr  <= '0;
        end else if (!signal_oe && signal_wr) begin
            if (signal_sel) begin
                numer_stage <= data_in;
                numer_attr  <= attr_in;
            end else begin
                denom_stage <= data_in;
                denom_attr  <= attr_in;
            end
        end
    end

    // operand latch and start pulse share the same edge.
    always_ff @(posedge clk) begin
        if (rst) begin
            numer <= '0;
            denom <= '0;
            start <= 1'b0;
        end else begin
            start <= bus_start;
            if (bus_start) begin
                numer.value   <= numer_stage;
                numer.invalid <= numer_attr[INVALID];
                denom.value   <= denom_stage;
                denom.invalid <= denom_attr[INVALID];
            end
        end
    end

endmodule

/* div_ctrl_pkg.sv */
package div_ctrl_pkg;

    import div_cfg_pkg::*;

    // sequencing of a single division.
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DONE
    } div_state_t;

    // one operand as latched at start.
    typedef struct packed {
        data_t value;
        logic  invalid;  // taken from attribute bit INVALID.
    } operand_t;

    // what the datapath hands to the result registers.
    typedef struct packed {
        data_t quotient;
        data_t remain;
        logic  invalid;
    } result_t;

endpackage

/* div_cfg_pkg.sv */
package div_cfg_pkg;

    // operand and result word width.
    localparam int DATA_WIDTH = 16;

    // attribute word width.
    localparam int ATTR_WIDTH = 4;

    // attribute bit that carries the invalid flag.
    localparam int INVALID = 0;

    // one restoring step per quotient bit.
    localparam int STEP_COUNT = DATA_WIDTH;

    // wide enough to index every step.
    localparam int STEP_W = $clog2(STEP_COUNT);

    // operand and result words.
    typedef logic [DATA_WIDTH-1:0] data_t;

    // attribute words as they travel on the bus.
    typedef logic [ATTR_WIDTH-1:0] attr_t;

    // step index inside one division.
    typedef logic [STEP_W-1:0] step_t;

endpackage
